//--- verilog/gfx_defines.svh
// Video control core register map
// Register indexes, field bit positions and the visible window limits
// shared by the register bank, the colour stage and the top level

`ifndef GFX_DEFINES_SVH
`define GFX_DEFINES_SVH

// Register bank size
`define GFX_REG_CNT      8

// Mode register, layout options
`define GFX_REG_MODE     3'd3
`define GFX_BIT_NARROW   6

// Colour register, tile window and palette bank
`define GFX_REG_COLOUR   3'd6
`define GFX_BIT_SCRWIN   3
`define GFX_PAL_LSB      4

// Control register, interrupts and screen flip
`define GFX_REG_CTRL     3'd7
`define GFX_BIT_NMI_EN   0
`define GFX_BIT_IRQ_EN   1
`define GFX_BIT_FLIP     3
`define GFX_BIT_NMI_PACE 4

// Border limits in screen counter units
`define GFX_TOP_BORDER   9'd16
`define GFX_WIDE_LEFT    9'd16
`define GFX_WIDE_RIGHT   9'd272
`define GFX_NARROW_LEFT  9'd24
`define GFX_NARROW_RIGHT 9'd264

`endif

//--- verilog/gfx_pkg.sv
// Video control core types
// Widths of the screen counters, CPU registers, colour values and
// graphics ROM bus, plus the ROM arbiter states

package gfx_pkg;

    // Screen position, hdump and vdump
    typedef logic [8:0] pos_t;

    // CPU register bank
    typedef logic [2:0] reg_addr_t;
    typedef logic [7:0] reg_t;

    // Pixel path
    typedef logic [7:0] pxl_idx_t;
    typedef logic [3:0] pal_t;
    // Palette bank, layer bit, colour nibble
    typedef logic [6:0] colour_t;

    // Graphics ROM port
    typedef logic [17:0] rom_addr_t;
    typedef logic [15:0] rom_data_t;

    // PROM load address, MSB picks the tile PROM
    typedef logic [8:0] prog_addr_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_settle,
        arb_wait
    } arb_state_t;

endpackage

//--- verilog/gfx_regs.sv
// CPU configuration register bank
// Eight byte-wide registers written by the CPU, read back without a
// clock, and decoded into the control fields used by the core

`timescale 1ns/1ps

`include "gfx_defines.svh"

module gfx_regs
    import gfx_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cs,
    input  logic      we,
    input  reg_addr_t addr,
    input  reg_t      din,
    output reg_t      dout,
    output logic      irq_en,
    output logic      nmi_en,
    output logic      nmi_pace,
    output logic      flip,
    output logic      narrow_en,
    output logic      scrwin_en,
    output logic [1:0] pal_bank
);

    reg_t mmr [`GFX_REG_CNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mmr <= '{default: '0};
        end else if (cs && we) begin
            mmr[addr] <= din;
        end
    end

    // Read-back follows addr directly
    assign dout = mmr[addr];

    // Mode register
    assign narrow_en = mmr[`GFX_REG_MODE][`GFX_BIT_NARROW];

    // Colour register
    assign scrwin_en = mmr[`GFX_REG_COLOUR][`GFX_BIT_SCRWIN];
    assign pal_bank  = mmr[`GFX_REG_COLOUR][`GFX_PAL_LSB +: 2];

    // Control register
    assign nmi_en    = mmr[`GFX_REG_CTRL][`GFX_BIT_NMI_EN];
    assign irq_en    = mmr[`GFX_REG_CTRL][`GFX_BIT_IRQ_EN];
    assign flip      = mmr[`GFX_REG_CTRL][`GFX_BIT_FLIP];
    assign nmi_pace  = mmr[`GFX_REG_CTRL][`GFX_BIT_NMI_PACE];

endmodule

//--- verilog/gfx_irq.sv
// Interrupt generation
// IRQ once per frame at the start of vertical blank, held until the
// next active line; NMI as a one-cycle pulse every 16 or 32 lines

`timescale 1ns/1ps

module gfx_irq
    import gfx_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic lhbl,
    input  logic lvbl,
    input  pos_t vdump,
    input  logic irq_en,
    input  logic nmi_en,
    input  logic nmi_pace,
    output logic cpu_irqn,
    output logic cpu_nmin
);

    logic last_lhbl;
    logic last_lvbl;
    logic lvbl_fall;
    logic lhbl_fall;
    logic nmi_line;

    assign lvbl_fall = last_lvbl && !lvbl;
    assign lhbl_fall = last_lhbl && !lhbl;
    // Every 16th line, or every 32nd when paced
    assign nmi_line  = (&vdump[3:0]) && (vdump[4] || !nmi_pace);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_lhbl <= 1'b0;
            last_lvbl <= 1'b0;
            cpu_irqn  <= 1'b1;
            cpu_nmin  <= 1'b1;
        end else begin
            last_lhbl <= lhbl;
            last_lvbl <= lvbl;
            if (lvbl_fall && irq_en) begin
                cpu_irqn <= 1'b0;
            end else if (lhbl || !irq_en) begin
                cpu_irqn <= 1'b1;
            end
            cpu_nmin <= !(lhbl_fall && nmi_en && nmi_line);
        end
    end

    // A falling lhbl cannot repeat on the next cycle
    nmi_single_pulse: assert property (@(posedge clk) disable iff (rst)
        !cpu_nmin |=> cpu_nmin);

endmodule

//--- verilog/gfx_rom_arb.sv
// Graphics ROM arbiter
// Shares one ROM port between the tile and sprite fetchers. Tile
// requests win. Each enabled request waits one settle cycle after
// rom_cs rises, then takes the first rom_ok. Disabled layers get zero

`timescale 1ns/1ps

module gfx_rom_arb
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] layer_en,
    input  logic       scr_valid,
    input  rom_addr_t  scr_addr,
    input  logic       obj_valid,
    input  rom_addr_t  obj_addr,
    input  rom_data_t  rom_data,
    input  logic       rom_ok,
    output logic       scr_ready,
    output rom_data_t  scr_data,
    output logic       scr_data_valid,
    output logic       obj_ready,
    output rom_data_t  obj_data,
    output logic       obj_data_valid,
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    output logic       rom_obj_sel
);

    arb_state_t state;
    logic scr_take;
    logic obj_take;
    logic rom_done;

    assign scr_ready = state == arb_idle;
    assign obj_ready = state == arb_idle && !scr_valid;
    assign scr_take  = scr_valid && scr_ready;
    assign obj_take  = obj_valid && obj_ready;
    assign rom_done  = state == arb_wait && rom_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= arb_idle;
            rom_cs         <= 1'b0;
            rom_obj_sel    <= 1'b0;
            scr_data_valid <= 1'b0;
            obj_data_valid <= 1'b0;
        end else begin
            scr_data_valid <= (scr_take && !layer_en[0]) || (rom_done && !rom_obj_sel);
            obj_data_valid <= (obj_take && !layer_en[1]) || (rom_done && rom_obj_sel);
            case (state)
                arb_idle: begin
                    if ((scr_take && layer_en[0]) || (obj_take && layer_en[1])) begin
                        rom_cs      <= 1'b1;
                        rom_obj_sel <= !scr_take;
                        state       <= arb_settle;
                    end
                end
                // rom_ok may still be high from the previous access
                arb_settle: state <= arb_wait;
                arb_wait: begin
                    if (rom_ok) begin
                        rom_cs <= 1'b0;
                        state  <= arb_idle;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (scr_take) begin
            rom_addr <= scr_addr;
        end else if (obj_take) begin
            rom_addr <= obj_addr;
        end
        if (scr_take && !layer_en[0]) begin
            scr_data <= '0;
        end else if (rom_done && !rom_obj_sel) begin
            scr_data <= rom_data;
        end
        if (obj_take && !layer_en[1]) begin
            obj_data <= '0;
        end else if (rom_done && rom_obj_sel) begin
            obj_data <= rom_data;
        end
    end

    rom_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom_cs && $past(rom_cs) |-> $stable(rom_addr) && $stable(rom_obj_sel));

    // Only one owner completes per cycle
    data_valid_onehot: assert property (@(posedge clk) disable iff (rst)
        !(scr_data_valid && obj_data_valid));

endmodule

//--- verilog/gfx_colour_prom.sv
// Pixel pipeline stage 1
// Looks up the tile and sprite colour PROMs and decides whether the
// pixel lies in the border. PROMs are loaded one entry per clock

`timescale 1ns/1ps

`include "gfx_defines.svh"

module gfx_colour_prom
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  pal_t       prog_data,
    input  logic       in_valid,
    input  pxl_idx_t   tile_pxl,
    input  logic       scrwin,
    input  pxl_idx_t   obj_pxl,
    input  pos_t       hdump,
    input  pos_t       vdump,
    input  logic       narrow_en,
    input  logic       s1_ready,
    output logic       in_ready,
    output logic       s1_valid,
    output pal_t       tile_col,
    output pal_t       obj_col,
    output logic       tile_prio_raw,
    output logic       blank
);

    pal_t tile_prom [256];
    pal_t obj_prom  [256];
    logic accept;
    logic border_wide;
    logic border_narrow;

    assign in_ready = !s1_valid || s1_ready;
    assign accept   = in_valid && in_ready;

    assign border_wide   = hdump < `GFX_WIDE_LEFT || hdump >= `GFX_WIDE_RIGHT;
    assign border_narrow = narrow_en &&
                           (hdump < `GFX_NARROW_LEFT || hdump >= `GFX_NARROW_RIGHT);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= accept || (s1_valid && !s1_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (prog_we && prog_addr[8]) begin
            tile_prom[prog_addr[7:0]] <= prog_data;
        end
        if (prog_we && !prog_addr[8]) begin
            obj_prom[prog_addr[7:0]] <= prog_data;
        end
        // Reads advance only when a pixel is taken
        if (accept) begin
            tile_col      <= tile_prom[tile_pxl];
            obj_col       <= obj_prom[obj_pxl];
            tile_prio_raw <= scrwin;
            blank         <= vdump < `GFX_TOP_BORDER || border_wide || border_narrow;
        end
    end

endmodule

//--- verilog/gfx_mixer.sv
// Pixel pipeline stage 2
// Chooses between the tile and sprite colours, adds the palette bank
// and blanks the border. Output is held while out_ready is low

`timescale 1ns/1ps

module gfx_mixer
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s1_valid,
    input  pal_t       tile_col,
    input  pal_t       obj_col,
    input  logic       tile_prio_raw,
    input  logic       blank,
    input  logic       scrwin_en,
    input  logic [1:0] pal_bank,
    input  logic       out_ready,
    output logic       s1_ready,
    output logic       out_valid,
    output colour_t    pxl_out
);

    logic    take;
    logic    tile_wins;
    colour_t mixed;

    assign s1_ready = !out_valid || out_ready;
    assign take     = s1_valid && s1_ready;

    // Transparent sprite, or tile window over a solid tile
    assign tile_wins = obj_col == '0 ||
                       (scrwin_en && tile_prio_raw && tile_col != '0);

    always_comb begin
        if (blank) begin
            mixed = '0;
        end else if (tile_wins) begin
            mixed = {pal_bank, 1'b1, tile_col};
        end else begin
            mixed = {pal_bank, 1'b0, obj_col};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= take || (out_valid && !out_ready);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pxl_out <= mixed;
        end
    end

    // Stalled pixel must not change under the consumer
    out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(pxl_out));

endmodule

//--- verilog/gfx_top.sv
// Video control core top level
// Register bank, interrupt logic, graphics ROM arbiter and the
// two-stage pixel pipeline on a single clock

`timescale 1ns/1ps

`include "gfx_defines.svh"

module gfx_top
    import gfx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // CPU port
    input  logic       cs,
    input  logic       we,
    input  reg_addr_t  addr,
    input  reg_t       din,
    output reg_t       dout,
    // Screen timing and interrupts
    input  logic       lhbl,
    input  logic       lvbl,
    input  pos_t       vdump,
    output logic       cpu_irqn,
    output logic       cpu_nmin,
    output logic       flip,
    // Fetch requesters
    input  logic       scr_valid,
    input  rom_addr_t  scr_addr,
    output logic       scr_ready,
    output rom_data_t  scr_data,
    output logic       scr_data_valid,
    input  logic       obj_valid,
    input  rom_addr_t  obj_addr,
    output logic       obj_ready,
    output rom_data_t  obj_data,
    output logic       obj_data_valid,
    input  logic [1:0] layer_en,
    // Graphics ROM
    output logic       rom_cs,
    output rom_addr_t  rom_addr,
    output logic       rom_obj_sel,
    input  rom_data_t  rom_data,
    input  logic       rom_ok,
    // PROM load
    input  logic       prog_we,
    input  prog_addr_t prog_addr,
    input  pal_t       prog_data,
    // Pixel stream
    input  logic       in_valid,
    output logic       in_ready,
    input  pxl_idx_t   tile_pxl,
    input  logic       scrwin,
    input  pxl_idx_t   obj_pxl,
    input  pos_t       hdump,
    output logic       out_valid,
    input  logic       out_ready,
    output colour_t    pxl_out
);

    // Configuration fields
    logic       irq_en;
    logic       nmi_en;
    logic       nmi_pace;
    logic       narrow_en;
    logic       scrwin_en;
    logic [1:0] pal_bank;

    // Stage 1 to stage 2
    logic s1_valid;
    logic s1_ready;
    pal_t tile_col;
    pal_t obj_col;
    logic tile_prio_raw;
    logic blank;

    // Port names match the wire names throughout
    gfx_regs        u_regs  (.*);
    gfx_irq         u_irq   (.*);
    gfx_rom_arb     u_arb   (.*);
    gfx_colour_prom u_prom  (.*);
    gfx_mixer       u_mixer (.*);

endmodule

//--- verification/gfx_tb_model.svh
// Reference model for the video control core testbench
// Expected ROM words, border blanking, layer mixing and interrupt lines

`ifndef GFX_TB_MODEL_SVH
`define GFX_TB_MODEL_SVH

// Word returned by the ROM responder, or zero for a disabled layer
function automatic logic [15:0] rom_word(input logic [17:0] a, input logic en);
    return en ? (a[15:0] ^ 16'hA5C3) : 16'h0000;
endfunction

// Top border, wide window and optional narrow window
function automatic logic pixel_blank(input logic [8:0] h, input logic [8:0] v,
                                     input logic narrow);
    if (v < 16 || h < 16 || h >= 272)
        return 1'b1;
    return narrow && (h < 24 || h >= 264);
endfunction

function automatic logic [6:0] mix_pixel(input logic [3:0] tc, input logic [3:0] oc,
                                         input logic prio, input logic blk,
                                         input logic win_en, input logic [1:0] pal);
    if (blk)
        return 7'd0;
    if (oc == 4'd0 || (win_en && prio && tc != 4'd0))
        return {pal, 1'b1, tc};
    return {pal, 1'b0, oc};
endfunction

// Next IRQ line from the current one and the sampled inputs
function automatic logic irq_next(input logic irqn, input logic prev_lv,
                                  input logic lv, input logic lh, input logic en);
    if (prev_lv && !lv && en)
        return 1'b0;
    if (lh || !en)
        return 1'b1;
    return irqn;
endfunction

function automatic logic nmi_next(input logic prev_lh, input logic lh,
                                  input logic [8:0] vd, input logic en,
                                  input logic pace);
    return !(prev_lh && !lh && en && vd[3:0] == 4'hF && (vd[4] || !pace));
endfunction

`endif

//--- verification/gfx_tb.sv
// Testbench for the video control core
// Random stimulus from a fixed seed, checked against the model functions

`timescale 1ns/1ps

`include "gfx_tb_model.svh"

module gfx_tb
    import gfx_pkg::*;
();

    logic clk, rst, cs, we, lhbl, lvbl, cpu_irqn, cpu_nmin, flip;
    reg_addr_t addr;
    reg_t din, dout;
    pos_t vdump, hdump;
    logic scr_valid, scr_ready, scr_data_valid, obj_valid, obj_ready, obj_data_valid;
    rom_addr_t scr_addr, obj_addr, rom_addr;
    rom_data_t scr_data, obj_data, rom_data;
    logic [1:0] layer_en;
    logic rom_cs, rom_obj_sel, rom_ok, prog_we, in_valid, in_ready, scrwin;
    prog_addr_t prog_addr;
    pal_t prog_data;
    pxl_idx_t tile_pxl, obj_pxl;
    logic out_valid, out_ready;
    colour_t pxl_out;

    integer seed = 45790;
    int cyc, errors, checks, base_err;
    reg_t shadow [8];
    pal_t tile_mem [256];
    pal_t obj_mem [256];
    rom_data_t scr_exp[$], obj_exp[$];
    rom_addr_t scr_cur, obj_cur;
    logic rom_owner;
    int scr_got, obj_got, resp_cnt, pix_got;
    logic resp_busy, arb_on, pix_on, check_latency, stalled, px_done;
    colour_t pix_exp[$], held;
    int pix_cyc[$];

    gfx_top uut (.*);

    always #4 clk = !clk;

    always @(posedge clk) begin
        cyc++;
        if (cyc >= 20000) begin
            $display("Timeout: the run did not finish within 20000 cycles");
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR t=%0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, errors - base_err);
        base_err = errors;
    endtask

    task automatic cpu_write(input reg_addr_t a, input reg_t d);
        @(posedge clk);
        cs <= 1'b1;
        we <= 1'b1;
        addr <= a;
        din <= d;
        shadow[a] = d;
        @(posedge clk);
        cs <= 1'b0;
        we <= 1'b0;
    endtask

    task automatic run_irq_block(input int n);
        logic lh, lv, pv_lh, pv_lv, m_irqn, m_nmin;
        pos_t vd;
        reg_t ctrl;
        ctrl = $random(seed);
        @(posedge clk);
        lhbl <= 1'b1;
        lvbl <= 1'b1;
        cpu_write(3'd7, ctrl);
        repeat (3) @(posedge clk);
        check_value("flip", ctrl[3], flip);
        {pv_lh, pv_lv, m_irqn, m_nmin} = 4'hF;
        lh = $random(seed);
        lv = $random(seed);
        vd = $random(seed);
        lhbl <= lh;
        lvbl <= lv;
        vdump <= vd;
        repeat (n) begin
            @(posedge clk);
            m_irqn = irq_next(m_irqn, pv_lv, lv, lh, ctrl[1]);
            m_nmin = nmi_next(pv_lh, lh, vd, ctrl[0], ctrl[4]);
            pv_lh = lh;
            pv_lv = lv;
            lh = $random(seed);
            lv = $random(seed);
            vd = $random(seed);
            lhbl <= lh;
            lvbl <= lv;
            vdump <= vd;
            @(negedge clk);
            check_value("cpu_irqn", m_irqn, cpu_irqn);
            check_value("cpu_nmin", m_nmin, cpu_nmin);
        end
    endtask

    // One requester, one request in flight at a time
    task automatic fetch_side(input logic obj_side, input int n);
        rom_addr_t a;
        logic hs;
        for (int i = 0; i < n; i++) begin
            a = $random(seed);
            repeat ({$random(seed)} % 4 + 1) @(posedge clk);
            if (obj_side) begin
                obj_valid <= 1'b1;
                obj_addr <= a;
            end else begin
                scr_valid <= 1'b1;
                scr_addr <= a;
            end
            do begin
                @(negedge clk);
                hs = obj_side ? obj_ready : scr_ready;
                @(posedge clk);
            end while (!hs);
            // An enabled request now owns the ROM port
            if (layer_en[obj_side])
                rom_owner = obj_side;
            if (obj_side) begin
                obj_valid <= 1'b0;
                obj_cur = a;
                obj_exp.push_back(rom_word(a, layer_en[1]));
                while (obj_exp.size() != 0) @(negedge clk);
            end else begin
                scr_valid <= 1'b0;
                scr_cur = a;
                scr_exp.push_back(rom_word(a, layer_en[0]));
                while (scr_exp.size() != 0) @(negedge clk);
            end
        end
    endtask

    task automatic run_fetches(input logic [1:0] en, input int n);
        @(posedge clk);
        layer_en <= en;
        scr_got = 0;
        obj_got = 0;
        arb_on = 1'b1;
        fork
            fetch_side(1'b0, n);
            fetch_side(1'b1, n);
        join
        repeat (2) @(negedge clk);
        arb_on = 1'b0;
        check_value("tile responses", n, scr_got);
        check_value("sprite responses", n, obj_got);
    endtask

    // Slow ROM with a random access time
    always @(posedge clk) begin
        if (rom_ok) begin
            rom_ok <= 1'b0;
            resp_busy <= 1'b0;
        end else if (resp_busy) begin
            if (resp_cnt <= 1) begin
                rom_ok <= 1'b1;
                rom_data <= rom_addr[15:0] ^ 16'hA5C3;
            end else begin
                resp_cnt <= resp_cnt - 1;
            end
        end else if (rom_cs) begin
            resp_busy <= 1'b1;
            resp_cnt <= {$random(seed)} % 6 + 1;
        end
    end

    always @(negedge clk) begin
        if (arb_on) begin
            if (scr_data_valid) begin
                scr_got++;
                if (scr_exp.size() == 0) begin
                    errors++;
                    $display("Tile fetcher got an unrequested response");
                end else begin
                    check_value("scr_data", scr_exp.pop_front(), scr_data);
                end
            end
            if (obj_data_valid) begin
                obj_got++;
                if (obj_exp.size() == 0) begin
                    errors++;
                    $display("Sprite fetcher got an unrequested response");
                end else begin
                    check_value("obj_data", obj_exp.pop_front(), obj_data);
                end
            end
            if (rom_cs) begin
                if (!layer_en[rom_obj_sel]) begin
                    errors++;
                    $display("ROM was selected for a disabled layer at t=%0t", $time);
                end
                check_value("rom_obj_sel", rom_owner, rom_obj_sel);
                check_value("rom_addr", rom_owner ? obj_cur : scr_cur, rom_addr);
            end
            if (scr_valid && obj_valid && scr_ready)
                check_value("obj_ready", 1'b0, obj_ready);
        end
    end

    task automatic set_pixel_regs();
        cpu_write(3'd3, $random(seed));
        cpu_write(3'd6, $random(seed));
    endtask

    task automatic send_pixels(input int n, input logic gaps);
        pxl_idx_t t, o;
        logic w, hs;
        pos_t h, v;
        int c;
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            if (gaps && {$random(seed)} % 3 == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            t = $random(seed);
            o = $random(seed);
            w = $random(seed);
            h = {$random(seed)} % 384;
            v = {$random(seed)} % 256;
            in_valid <= 1'b1;
            tile_pxl <= t;
            obj_pxl <= o;
            scrwin <= w;
            hdump <= h;
            vdump <= v;
            do begin
                @(negedge clk);
                hs = in_ready;
                c = cyc;
                @(posedge clk);
            end while (!hs);
            pix_cyc.push_back(c);
            pix_exp.push_back(mix_pixel(tile_mem[t], obj_mem[o], w,
                                        pixel_blank(h, v, shadow[3][6]),
                                        shadow[6][3], shadow[6][5:4]));
        end
        in_valid <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (pix_on) begin
            // Both stages full and the output stalled
            check_value("in_ready", !(pix_exp.size() == 2 && !out_ready), in_ready);
            if (stalled) begin
                check_value("out_valid", 1'b1, out_valid);
                check_value("pxl_out", held, pxl_out);
            end
            if (out_valid && out_ready) begin
                pix_got++;
                if (pix_exp.size() == 0) begin
                    errors++;
                    $display("Pixel came out that was never sent");
                end else begin
                    check_value("pxl_out", pix_exp.pop_front(), pxl_out);
                    if (check_latency)
                        check_value("latency", pix_cyc[0] + 2, cyc);
                    void'(pix_cyc.pop_front());
                end
            end
            stalled = out_valid && !out_ready;
            held = pxl_out;
        end
    end

    initial begin
        {clk, cs, we, addr, din, vdump, hdump, scr_valid, scr_addr} = '0;
        {obj_valid, obj_addr, rom_data, rom_ok, prog_we, prog_addr, prog_data} = '0;
        {in_valid, tile_pxl, scrwin, obj_pxl, resp_busy, resp_cnt} = '0;
        {arb_on, pix_on, check_latency, stalled, px_done, held, rom_owner} = '0;
        lhbl = 1'b1;
        lvbl = 1'b1;
        out_ready = 1'b1;
        layer_en = 2'b11;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 8; i++)
            cpu_write(i, $random(seed));
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            addr <= i;
            @(negedge clk);
            check_value("dout", shadow[i], dout);
        end
        check_value("flip", shadow[7][3], flip);
        end_test("test 1 register bank");

        repeat (4) run_irq_block(200);
        end_test("test 2 interrupts");

        run_fetches(2'b11, 40);
        end_test("test 3 ROM arbitration");

        run_fetches(2'b10, 20);
        run_fetches(2'b01, 20);
        @(posedge clk);
        layer_en <= 2'b11;
        end_test("test 4 layer enable");

        for (int i = 0; i < 512; i++) begin
            @(posedge clk);
            prog_we <= 1'b1;
            prog_addr <= i;
            prog_data <= i[3:0] ^ i[7:4] ^ {3'b0, i[8]} ^ 4'($random(seed));
            @(negedge clk);
            if (i[8]) tile_mem[i[7:0]] = prog_data;
            else obj_mem[i[7:0]] = prog_data;
        end
        @(posedge clk);
        prog_we <= 1'b0;
        pix_on = 1'b1;
        check_latency = 1'b1;
        pix_got = 0;
        for (int b = 0; b < 3; b++) begin
            set_pixel_regs();
            send_pixels(100, 1'b0);
            while (pix_exp.size() != 0) @(negedge clk);
        end
        check_value("pixels out", 300, pix_got);
        end_test("test 5 pixel pipeline");

        check_latency = 1'b0;
        pix_got = 0;
        set_pixel_regs();
        fork
            begin
                send_pixels(200, 1'b1);
                px_done = 1'b1;
            end
            while (!px_done) begin
                @(posedge clk);
                out_ready <= $random(seed);
            end
        join
        @(posedge clk);
        out_ready <= 1'b1;
        while (pix_exp.size() != 0) @(negedge clk);
        check_value("pixels out", 200, pix_got);
        end_test("test 6 back-pressure");

        $display("tests 6, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
+incdir+verification
verilog/gfx_pkg.sv
verilog/gfx_regs.sv
verilog/gfx_irq.sv
verilog/gfx_rom_arb.sv
verilog/gfx_colour_prom.sv
verilog/gfx_mixer.sv
verilog/gfx_top.sv
verification/gfx_tb.sv

//--- Makefile
# Verilator build for the video control core

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module gfx_top

sim:
	verilator --binary --timing --assert -f flist.f --top-module gfx_tb -o gfx_sim
	./obj_dir/gfx_sim | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
